/* sem_mon.f */
hw/sem_mon_pkg.sv
hw/sem_event_if.sv
hw/mon_char_stage.sv
hw/mon_token_decoder.sv
hw/sem_err_log.sv
hw/sem_cmd_fifo.sv
hw/sem_mon_top.sv
verification/sem_mon_asserts.sv
verification/tb_sem_mon.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sem_mon testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_sem_mon \
	-f sem_mon.f \
	-Mdir obj_dir \
	-o sim_sem_mon

./obj_dir/sim_sem_mon | tee sim.log

if grep -q "^>>> PASS$" sim.log; then
	echo "sem_mon simulation passed"
	exit 0
else
	echo "sem_mon simulation failed, see sim.log"
	exit 1
fi

/* verification/tb_sem_mon.sv */
`timescale 1ns/1ps

module tb_sem_mon;

	logic        CLK40 = 1'b0;
	logic        RST;
	logic [6:0]  status_in;   // Bit 0 initialization .. bit 6 uncorrectable
	logic        fecc_crcerr;
	logic [7:0]  monitor_txdata;
	logic        monitor_txwrite;
	logic        monitor_rxread;
	logic        jtag_ded_rst;
	logic        jtag_rst_sem_cntrs;
	logic        jtag_send_cmd;
	logic [7:0]  jtag_cmd_data;
	logic [7:0]  monitor_rxdata;
	logic        monitor_rxempty;
	logic [23:0] sem_far_pa;
	logic [23:0] sem_far_la;
	logic [15:0] sem_errcnt;
	logic [15:0] sem_status;

	integer      seed = 32'h3367_3891;
	logic [31:0] rnd; // Last random word

	// Reference model state
	sem_mon_pkg::monitor_window_t m_win;
	logic [7:0]  m_sngl;
	logic [7:0]  m_dbl;
	logic        m_flag;
	logic [23:0] m_pa;
	logic [23:0] m_la;
	logic [7:0]  m_cmd_q [$]; // Expected FIFO contents, head first

	always #4 CLK40 = ~CLK40; // 8 ns period

	sem_mon_top UUT (
		.CLK40 (CLK40), .RST (RST),
		.status_initialization (status_in[0]), .status_observation   (status_in[1]),
		.status_correction     (status_in[2]), .status_classification (status_in[3]),
		.status_injection      (status_in[4]), .status_essential      (status_in[5]),
		.status_uncorrectable  (status_in[6]), .fecc_crcerr (fecc_crcerr),
		.monitor_txdata (monitor_txdata), .monitor_txwrite (monitor_txwrite),
		.monitor_rxread (monitor_rxread), .monitor_rxdata  (monitor_rxdata),
		.monitor_rxempty (monitor_rxempty), .jtag_ded_rst (jtag_ded_rst),
		.jtag_rst_sem_cntrs (jtag_rst_sem_cntrs), .jtag_send_cmd (jtag_send_cmd),
		.jtag_cmd_data (jtag_cmd_data), .sem_far_pa (sem_far_pa), .sem_far_la (sem_far_la),
		.sem_errcnt (sem_errcnt), .sem_status (sem_status)
	);

	bind sem_mon_top sem_mon_asserts u_asserts (
		.CLK40 (CLK40), .RST (RST), .jtag_ded_rst (jtag_ded_rst),
		.monitor_rxempty (monitor_rxempty), .sem_status (sem_status)
	);

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	task automatic stop_on_error(input string why);
		$display("ERROR: %s", why);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	// Every visible register against the model
	task automatic check_all(input string name);
		logic [15:0] exp_status;
		exp_status      = '0;
		exp_status[6:0] = status_in;
		exp_status[sem_mon_pkg::ST_CRC_BIT] = fecc_crcerr;
		exp_status[sem_mon_pkg::ST_DED_BIT] = m_flag;
		check_value({name, " errcnt"}, 32'({m_dbl, m_sngl}), 32'(sem_errcnt));
		check_value({name, " status"}, 32'(exp_status), 32'(sem_status));
		check_value({name, " far_pa"}, 32'(m_pa), 32'(sem_far_pa));
		check_value({name, " far_la"}, 32'(m_la), 32'(sem_far_la));
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic logic [3:0] hex_value(input logic [7:0] c);
		if (c >= "0" && c <= "9")
			return 4'(c - "0");
		else if (c >= "a" && c <= "f")
			return 4'(c - "a" + 8'd10);
		else
			return 4'(c - "A" + 8'd10); // Upper case digit
	endfunction

	// One monitor byte into the model window
	task automatic model_write(input logic [7:0] b);
		logic sed_old;
		logic ded_old;
		logic pa_old;
		logic la_old;
		logic [23:0] far;
		sed_old = (m_win.chars[2:0] == sem_mon_pkg::TAG_SED);
		ded_old = (m_win.chars[2:0] == sem_mon_pkg::TAG_DED);
		pa_old  = (m_win.fields.tag == sem_mon_pkg::TAG_PA);
		la_old  = (m_win.fields.tag == sem_mon_pkg::TAG_LA);
		m_win.chars = {m_win.chars[7:0], b}; // Newest in slot 0
		far = '0;
		for (int k = 5; k >= 0; k--)
			far = {far[19:0], hex_value(m_win.fields.digits[k])}; // MSD first
		if (m_win.chars[2:0] == sem_mon_pkg::TAG_SED && !sed_old)
			m_sngl++; // Wraps like the counter
		if (m_win.chars[2:0] == sem_mon_pkg::TAG_DED && !ded_old) begin
			m_dbl++;
			m_flag = 1'b1;
		end
		if (m_win.fields.tag == sem_mon_pkg::TAG_PA && !pa_old)
			m_pa = far;
		if (m_win.fields.tag == sem_mon_pkg::TAG_LA && !la_old)
			m_la = far;
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	task automatic drive_status();
		rnd = $random(seed);
		status_in   = rnd[6:0];
		fecc_crcerr = rnd[7];
	endtask

	// Lowercase g..v or a decimal digit, never part of a tag
	function automatic logic [7:0] noise_of(input logic [31:0] r);
		if (r[8])
			return 8'h30 + {4'h0, r[3:0] % 4'd10};
		else
			return 8'h67 + {4'h0, r[7:4]};
	endfunction

	function automatic logic [7:0] hex_char(input logic [4:0] r);
		if (r[3:0] < 4'd10)
			return 8'h30 + {4'h0, r[3:0]};
		else if (r[4])
			return 8'h41 + {4'h0, r[3:0] - 4'd10}; // Upper case
		else
			return 8'h61 + {4'h0, r[3:0] - 4'd10};
	endfunction

	task automatic send_byte(input logic [7:0] b);
		@(negedge CLK40);
		monitor_txdata  = b;
		monitor_txwrite = 1'b1; // Stays high for back-to-back bytes
		model_write(b);
	endtask

	// Write, check two cycles later, then a random idle gap
	task automatic send_checked(input logic [7:0] b, input string name);
		send_byte(b);
		@(negedge CLK40);
		monitor_txwrite = 1'b0;
		@(negedge CLK40);
		check_all(name);
		drive_status();
		rnd = $random(seed);
		repeat (rnd[1:0]) @(negedge CLK40);
	endtask

	task automatic send_tag(input logic [23:0] tag, input string name);
		for (int k = 2; k >= 0; k--)
			send_checked(tag[k*8 +: 8], name); // Oldest char first
	endtask

	// Tag, six digits and one trailing byte right behind the last digit
	task automatic send_report(input logic [23:0] tag);
		for (int k = 2; k >= 0; k--)
			send_byte(tag[k*8 +: 8]);
		repeat (6) begin
			rnd = $random(seed);
			send_byte(hex_char(rnd[4:0]));
		end
		rnd = $random(seed);
		send_byte(noise_of(rnd)); // Lands on the load cycle
		@(negedge CLK40);
		monitor_txwrite = 1'b0;
		repeat (2) @(negedge CLK40);
		check_all(tag == sem_mon_pkg::TAG_PA ? "PA report" : "LA report");
		drive_status();
	endtask

	// Check the head, then pop it
	task automatic pop_one(input string name);
		check_value({name, " rxempty"}, 32'(m_cmd_q.size() == 0), 32'(monitor_rxempty));
		if (m_cmd_q.size() != 0)
			check_value({name, " rxdata"}, 32'(m_cmd_q[0]), 32'(monitor_rxdata));
		monitor_rxread = 1'b1;
		@(negedge CLK40);
		monitor_rxread = 1'b0;
		if (m_cmd_q.size() != 0)
			void'(m_cmd_q.pop_front());
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		int tries;
		int burst;
		RST                = 1'b1;
		monitor_txdata     = 8'h00;
		monitor_txwrite    = 1'b0;
		monitor_rxread     = 1'b0;
		jtag_ded_rst       = 1'b0;
		jtag_rst_sem_cntrs = 1'b0;
		jtag_send_cmd      = 1'b0;
		jtag_cmd_data      = 8'h00;
		drive_status();
		m_win.chars = {sem_mon_pkg::WINDOW_CHARS{sem_mon_pkg::CHAR_SPACE}}; // Idle spaces
		m_sngl = '0;
		m_dbl  = '0;
		m_flag = 1'b0;
		m_pa   = '0;
		m_la   = '0;
		repeat (16) @(negedge CLK40);
		RST = 1'b0;
		@(negedge CLK40);

		// Reset values
		check_all("reset");
		check_value("reset rxempty", 32'(1), 32'(monitor_rxempty));

		// SED, DED and noise, enough SEDs to wrap the count
		repeat (700) begin
			rnd = $random(seed);
			case (rnd[1:0])
				2'd0, 2'd1: send_tag(sem_mon_pkg::TAG_SED, "SED message");
				2'd2:       send_tag(sem_mon_pkg::TAG_DED, "DED message");
				default:    send_checked(noise_of(rnd >> 2), "noise byte");
			endcase
		end

		// Frame address reports
		repeat (20) begin
			rnd = $random(seed);
			send_report(rnd[0] ? sem_mon_pkg::TAG_PA : sem_mon_pkg::TAG_LA);
		end

		// JTAG clears, then counting restarts at zero
		send_tag(sem_mon_pkg::TAG_DED, "DED before clear");
		jtag_ded_rst = 1'b1;
		@(negedge CLK40);
		jtag_ded_rst = 1'b0;
		m_flag = 1'b0;
		m_pa   = '0;
		m_la   = '0;
		@(negedge CLK40);
		check_all("after ded_rst");
		jtag_rst_sem_cntrs = 1'b1;
		@(negedge CLK40);
		jtag_rst_sem_cntrs = 1'b0;
		m_sngl = '0;
		m_dbl  = '0;
		@(negedge CLK40);
		check_all("after counter clear");
		send_tag(sem_mon_pkg::TAG_SED, "SED after clear");
		send_tag(sem_mon_pkg::TAG_DED, "DED after clear");
		check_value("count restart", 32'(16'h0101), 32'(sem_errcnt));

		// Command bursts, some past capacity
		repeat (6) begin
			rnd = $random(seed);
			burst = 1 + int'(rnd[4:0]);
			repeat (burst) begin
				@(negedge CLK40);
				rnd = $random(seed);
				jtag_send_cmd = 1'b1;
				jtag_cmd_data = rnd[7:0];
				if (m_cmd_q.size() < sem_mon_pkg::CMD_DEPTH)
					m_cmd_q.push_back(rnd[7:0]); // Full FIFO drops it
			end
			@(negedge CLK40);
			jtag_send_cmd = 1'b0;
			rnd = $random(seed);
			repeat (rnd[3:0]) pop_one("fifo pop");
		end
		tries = 0;
		while (!monitor_rxempty && tries < 64) begin
			pop_one("fifo drain");
			tries++;
		end
		if (!monitor_rxempty)
			stop_on_error("command FIFO did not drain within 64 pops");
		pop_one("pop when empty");
		check_value("empty pop ignored", 32'(1), 32'(monitor_rxempty)); // Still empty

		$display(">>> PASS");
		$finish;
	end

	// Run limit
	initial begin
		#2_000_000;
		$display("Simulation ran past its time limit");
		$display(">>> FAIL");
		$fatal(1);
	end

endmodule

/* verification/sem_mon_asserts.sv */
`timescale 1ns/1ps

// Rules on the monitor top level, bound into sem_mon_top
module sem_mon_asserts (
	input logic        CLK40,
	input logic        RST,
	input logic        jtag_ded_rst,
	input logic        monitor_rxempty,
	input logic [15:0] sem_status
);

	////////////////////////////////////////
	// Status word
	////////////////////////////////////////

	// Bits 7 and 10 to 15 carry nothing
	reserved_bits_zero: assert property (
		@(posedge CLK40) disable iff (RST)
		(sem_status[7] == 1'b0) && (sem_status[15:10] == 6'd0)
	) else $error("sem_status has a reserved bit set");

	// Sticky DED flag only drops on a clear
	ded_flag_sticky: assert property (
		@(posedge CLK40) disable iff (RST)
		($past(sem_status[sem_mon_pkg::ST_DED_BIT]) && !sem_status[sem_mon_pkg::ST_DED_BIT])
			|-> ($past(jtag_ded_rst) || $past(RST))
	) else $error("DED flag fell without jtag_ded_rst or RST");

	////////////////////////////////////////
	// Command FIFO
	////////////////////////////////////////
	empty_after_reset: assert property (
		@(posedge CLK40)
		($past(RST) && !RST) |-> monitor_rxempty // First cycle out of reset
	) else $error("monitor_rxempty low right after reset");

endmodule

/* hw/sem_mon_top.sv */
`timescale 1ns/1ps

// User-side monitor next to the SEM core
module sem_mon_top (
	input  logic        CLK40,
	input  logic        RST,
	// Core status levels
	input  logic        status_initialization,
	input  logic        status_observation,
	input  logic        status_correction,
	input  logic        status_classification,
	input  logic        status_injection,
	input  logic        status_essential,
	input  logic        status_uncorrectable,
	input  logic        fecc_crcerr,        // CRC error level
	// Core monitor port
	input  logic [7:0]  monitor_txdata,
	input  logic        monitor_txwrite,
	input  logic        monitor_rxread,
	output logic [7:0]  monitor_rxdata,
	output logic        monitor_rxempty,
	// JTAG side
	input  logic        jtag_ded_rst,       // Clears DED flag and both FARs
	input  logic        jtag_rst_sem_cntrs, // Clears both counters
	input  logic        jtag_send_cmd,
	input  logic [7:0]  jtag_cmd_data,
	output logic [23:0] sem_far_pa,
	output logic [23:0] sem_far_la,
	output logic [15:0] sem_errcnt,         // {dbl, sngl}
	output logic [15:0] sem_status
);

	// chain[0] is the incoming byte, chain[i+1] is stage i
	logic [sem_mon_pkg::WINDOW_CHARS:0][sem_mon_pkg::CHAR_W-1:0] chain;
	logic [sem_mon_pkg::WINDOW_CHARS-1:0][3:0]                   nibbles;

	logic [sem_mon_pkg::ERRCNT_W-1:0] sngl_cnt;
	logic [sem_mon_pkg::ERRCNT_W-1:0] dbl_cnt;
	logic                             ded_flag;

	sem_event_if mon_ev ();

	////////////////////////////////////////
	// Character window
	////////////////////////////////////////
	assign chain[0] = monitor_txdata; // Stage 0 takes the core byte

	genvar i;
	generate
		for (i = 0; i < sem_mon_pkg::WINDOW_CHARS; i++) begin : g_stage
			mon_char_stage u_stage (
				.CLK40    (CLK40),
				.RST      (RST),
				.shift    (monitor_txwrite),
				.char_in  (chain[i]),
				.char_out (chain[i+1]),
				.nibble   (nibbles[i])
			);
		end
	endgenerate

	// Only the six digit slots carry a hex value
	mon_token_decoder u_decoder (
		.CLK40   (CLK40),
		.RST     (RST),
		.chars   (chain[sem_mon_pkg::WINDOW_CHARS:1]),
		.nibbles (nibbles[sem_mon_pkg::FAR_DIGITS-1:0]),
		.ev      (mon_ev.decoder)
	);

	sem_err_log u_err_log (
		.CLK40    (CLK40),
		.RST      (RST),
		.ded_rst  (jtag_ded_rst),
		.cntr_rst (jtag_rst_sem_cntrs),
		.ev       (mon_ev.log),
		.far_pa   (sem_far_pa),
		.far_la   (sem_far_la),
		.sngl_cnt (sngl_cnt),
		.dbl_cnt  (dbl_cnt),
		.ded_flag (ded_flag)
	);

	////////////////////////////////////////
	// Commands to the core
	////////////////////////////////////////
	sem_cmd_fifo u_cmd_fifo (
		.CLK40   (CLK40),
		.RST     (RST),
		.wr      (jtag_send_cmd),
		.wr_data (jtag_cmd_data),
		.rd      (monitor_rxread),
		.rd_data (monitor_rxdata),
		.empty   (monitor_rxempty)
	);

	assign sem_errcnt = {dbl_cnt, sngl_cnt};

	// Status word, unused bits zero
	always_comb begin
		sem_status = '0;
		sem_status[6:0] = {status_uncorrectable, status_essential, status_injection,
		                   status_classification, status_correction,
		                   status_observation, status_initialization};
		sem_status[sem_mon_pkg::ST_CRC_BIT] = fecc_crcerr;
		sem_status[sem_mon_pkg::ST_DED_BIT] = ded_flag; // Sticky DED
	end

endmodule

/* hw/sem_cmd_fifo.sv */
`timescale 1ns/1ps

// First-word fall-through FIFO for core commands
module sem_cmd_fifo (
	input  logic                           CLK40,
	input  logic                           RST,
	input  logic                           wr,      // JTAG command strobe
	input  logic [sem_mon_pkg::CHAR_W-1:0] wr_data,
	input  logic                           rd,      // Core pop
	output logic [sem_mon_pkg::CHAR_W-1:0] rd_data, // Head when not empty
	output logic                           empty
);

	localparam logic [sem_mon_pkg::CMD_PTR_W:0] FULL_CNT =
		(sem_mon_pkg::CMD_PTR_W + 1)'(sem_mon_pkg::CMD_DEPTH);

	logic [sem_mon_pkg::CHAR_W-1:0] mem [sem_mon_pkg::CMD_DEPTH];

	logic [sem_mon_pkg::CMD_PTR_W-1:0] wr_ptr;
	logic [sem_mon_pkg::CMD_PTR_W-1:0] rd_ptr;
	logic [sem_mon_pkg::CMD_PTR_W:0]   count;  // 0 to 16 entries

	logic full;
	logic do_wr;
	logic do_rd;

	assign full  = (count == FULL_CNT);
	assign empty = (count == '0);
	assign do_wr = wr & ~full;  // Drop when full
	assign do_rd = rd & ~empty; // Ignore pop when empty

	// Storage
	always_ff @(posedge CLK40) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// Pointers and occupancy
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	assign rd_data = mem[rd_ptr]; // Fall-through head

endmodule

/* hw/sem_err_log.sv */
`timescale 1ns/1ps

// Error counters, sticky DED flag and frame address capture
module sem_err_log (
	input  logic                             CLK40,
	input  logic                             RST,
	input  logic                             ded_rst,  // Clears flag and addresses
	input  logic                             cntr_rst, // Clears both counters
	sem_event_if.log                         ev,
	output logic [sem_mon_pkg::FAR_W-1:0]    far_pa,
	output logic [sem_mon_pkg::FAR_W-1:0]    far_la,
	output logic [sem_mon_pkg::ERRCNT_W-1:0] sngl_cnt,
	output logic [sem_mon_pkg::ERRCNT_W-1:0] dbl_cnt,
	output logic                             ded_flag
);

	////////////////////////////////////////
	// Error counters
	////////////////////////////////////////

	// Single error count, wraps at 255
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			sngl_cnt <= '0;
		else if (cntr_rst)
			sngl_cnt <= '0; // Clear wins over a pulse
		else if (ev.sed_pulse)
			sngl_cnt <= sngl_cnt + 1'b1;
	end

	// Double error count
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			dbl_cnt <= '0;
		else if (cntr_rst)
			dbl_cnt <= '0;
		else if (ev.ded_pulse)
			dbl_cnt <= dbl_cnt + 1'b1;
	end

	// Sticky DED flag
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			ded_flag <= 1'b0;
		else if (ded_rst)
			ded_flag <= 1'b0; // Clear beats a new DED
		else if (ev.ded_pulse)
			ded_flag <= 1'b1;
	end

	////////////////////////////////////////
	// Frame address registers
	////////////////////////////////////////

	// Physical address
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			far_pa <= '0;
		else if (ev.load_pa)
			far_pa <= ev.far_value; // Load beats clear
		else if (ded_rst)
			far_pa <= '0;
	end

	// Linear address
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			far_la <= '0;
		else if (ev.load_la)
			far_la <= ev.far_value;
		else if (ded_rst)
			far_la <= '0;
	end

endmodule

/* hw/mon_token_decoder.sv */
`timescale 1ns/1ps

// Report tag matching over the nine-character window
module mon_token_decoder (
	input  logic CLK40,
	input  logic RST,
	input  logic [sem_mon_pkg::WINDOW_CHARS-1:0][sem_mon_pkg::CHAR_W-1:0] chars, // 0 newest
	input  logic [sem_mon_pkg::FAR_DIGITS-1:0][3:0] nibbles, // 5 is the MSD
	sem_event_if.decoder ev
);

	sem_mon_pkg::monitor_window_t win;

	// Raw tag matches
	logic sed;
	logic ded;
	logic pa;
	logic la;

	// Match history for edge detect
	logic sed_r;
	logic ded_r;
	logic pa_r;
	logic la_r;

	// Address strobes wait one cycle for the nibbles
	logic load_pa_d;
	logic load_la_d;

	assign win = chars; // Same bits, two views

	////////////////////////////////////////
	// Tag compare
	////////////////////////////////////////
	assign sed = (win.chars[2:0] == sem_mon_pkg::TAG_SED); // Newest three chars
	assign ded = (win.chars[2:0] == sem_mon_pkg::TAG_DED);
	assign pa  = (win.fields.tag == sem_mon_pkg::TAG_PA);  // Oldest three chars
	assign la  = (win.fields.tag == sem_mon_pkg::TAG_LA);

	////////////////////////////////////////
	// Edge detect and strobe delay
	////////////////////////////////////////
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			sed_r     <= 1'b0;
			ded_r     <= 1'b0;
			pa_r      <= 1'b0;
			la_r      <= 1'b0;
			load_pa_d <= 1'b0;
			load_la_d <= 1'b0;
		end else begin
			sed_r     <= sed;
			ded_r     <= ded;
			pa_r      <= pa;
			la_r      <= la;
			load_pa_d <= pa & ~pa_r; // Rising edge, one cycle late
			load_la_d <= la & ~la_r;
		end
	end

	// Pulse only when a match newly appears
	assign ev.sed_pulse = sed & ~sed_r;
	assign ev.ded_pulse = ded & ~ded_r;
	assign ev.load_pa   = load_pa_d;
	assign ev.load_la   = load_la_d;

	// Six nibbles packed MSD first
	assign ev.far_value = {nibbles[5], nibbles[4], nibbles[3],
	                       nibbles[2], nibbles[1], nibbles[0]};

endmodule

/* hw/mon_char_stage.sv */
`timescale 1ns/1ps

// One character slot of the monitor window
module mon_char_stage (
	input  logic                           CLK40,
	input  logic                           RST,
	input  logic                           shift,    // Monitor write strobe
	input  logic [sem_mon_pkg::CHAR_W-1:0] char_in,  // From the newer neighbor
	output logic [sem_mon_pkg::CHAR_W-1:0] char_out, // To the older neighbor and decoder
	output logic [3:0]                     nibble    // Hex value of char_out
);

	logic [3:0] hex_adj; // Letter offset

	// Character register
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			char_out <= sem_mon_pkg::CHAR_SPACE; // Window idles on spaces
		else if (shift)
			char_out <= char_in;
	end

	// Bit 6 marks A-F and a-f
	assign hex_adj = char_out[6] ? 4'd9 : 4'd0;

	// Nibble trails the char by one edge
	always_ff @(posedge CLK40) begin
		nibble <= char_out[3:0] + hex_adj; // '0'..'9' pass through
	end

endmodule

/* hw/sem_event_if.sv */
`timescale 1ns/1ps

// Decoded monitor events, decoder to error log
interface sem_event_if;

	logic sed_pulse; // One cycle per new SED report
	logic ded_pulse; // One cycle per new DED report
	logic load_pa;   // Delayed strobe, nibbles settled
	logic load_la;
	logic [sem_mon_pkg::FAR_W-1:0] far_value; // Six digits, MSD on top

	// Producer side
	modport decoder (
		output sed_pulse,
		output ded_pulse,
		output load_pa,
		output load_la,
		output far_value
	);

	// Consumer side
	modport log (
		input sed_pulse,
		input ded_pulse,
		input load_pa,
		input load_la,
		input far_value
	);

endinterface

/* hw/sem_mon_pkg.sv */
package sem_mon_pkg;

	////////////////////////////////////////
	// Widths and depths
	////////////////////////////////////////
	localparam int CHAR_W       = 8;  // One monitor character
	localparam int WINDOW_CHARS = 9;  // Shift window length
	localparam int TAG_CHARS    = 3;  // Report tag length
	localparam int FAR_DIGITS   = 6;  // Hex digits per address report
	localparam int FAR_W        = 24; // Frame address width
	localparam int ERRCNT_W     = 8;  // Each error counter
	localparam int STATUS_W     = 16; // Packed status word
	localparam int CMD_DEPTH    = 16; // Command FIFO entries
	localparam int CMD_PTR_W    = 4;  // log2 of CMD_DEPTH

	// Idle fill of the window
	localparam logic [CHAR_W-1:0] CHAR_SPACE = 8'h20;

	////////////////////////////////////////
	// Report tags, oldest char in the MSB
	////////////////////////////////////////
	localparam logic [TAG_CHARS*CHAR_W-1:0] TAG_SED = "SED"; // Single error corrected
	localparam logic [TAG_CHARS*CHAR_W-1:0] TAG_DED = "DED"; // Double error detected
	localparam logic [TAG_CHARS*CHAR_W-1:0] TAG_PA  = "PA "; // Physical frame address
	localparam logic [TAG_CHARS*CHAR_W-1:0] TAG_LA  = "LA "; // Linear frame address

	// Status word positions above the seven core status bits
	localparam int ST_CRC_BIT = 8;
	localparam int ST_DED_BIT = 9;

	////////////////////////////////////////
	// Window views
	////////////////////////////////////////

	// Address report layout, tag first then the digits, MSD oldest
	typedef struct packed {
		logic [TAG_CHARS-1:0][CHAR_W-1:0]  tag;    // Oldest three chars
		logic [FAR_DIGITS-1:0][CHAR_W-1:0] digits; // digits[5] is the MSD
	} monitor_fields_t;

	// Same 72 bits, either as plain chars or as a report
	typedef union packed {
		logic [WINDOW_CHARS-1:0][CHAR_W-1:0] chars; // chars[0] is newest
		monitor_fields_t                     fields;
	} monitor_window_t;

endpackage
